// ==== mem_sub_cfg.svh ====
`ifndef MEM_SUB_CFG_SVH
`define MEM_SUB_CFG_SVH

// array geometry
`define MEM_WORDS       128
`define MEM_WORD_BITS   64
`define MEM_WRITE_BITS  8      // byte granule, 8 mask bits per word

// flow control
`define REQ_CREDITS     4      // also the request fifo depth
`define RESP_CREDITS    4      // response slots held by the requester

`define TAG_BITS        3

`endif

// ==== mem_sub_pkg.sv ====
`include "mem_sub_cfg.svh"

package mem_sub_pkg;

    typedef logic [$clog2(`MEM_WORDS)-1:0] mem_addr_t;
    typedef logic [`MEM_WORD_BITS-1:0] mem_data_t;

    // one bit per write granule
    typedef logic [`MEM_WORD_BITS/`MEM_WRITE_BITS-1:0] mem_mask_t;

    typedef logic [`TAG_BITS-1:0] mem_tag_t;

    // one queued request, as held in the scheduler fifo
    typedef struct packed {
        logic      write;
        mem_addr_t addr;
        mem_data_t data;
        mem_mask_t mask;    // ignored on reads
        mem_tag_t  tag;
    } mem_req_t;

endpackage

// ==== mem_port_if.sv ====
interface mem_port_if import mem_sub_pkg::*; ();

    logic      nce;     // chip enable, active low
    logic      nwe;     // write enable, active low
    mem_addr_t addr;
    mem_data_t wdata;
    mem_mask_t wmask;
    mem_data_t rdata;   // holds until the next read

    // scheduler side
    modport ctrl (
        output nce,
        output nwe,
        output addr,
        output wdata,
        output wmask,
        input  rdata
    );

    // memory side
    modport ram (
        input  nce,
        input  nwe,
        input  addr,
        input  wdata,
        input  wmask,
        output rdata
    );

endinterface

// ==== mem_rtl_1rw.sv ====
module mem_rtl_1rw #(
    parameter int WORD_SIZE  = 64,
    parameter int NUM_WORDS  = 128,
    parameter int WRITE_SIZE = 8
) (
    input logic      clk,
    mem_port_if.ram  port
);

    localparam int ADDR_BITS = $clog2(NUM_WORDS);
    localparam int MASK_BITS = WORD_SIZE / WRITE_SIZE;

    // behavioral array, zero at start of simulation
    logic [WORD_SIZE-1:0] array [NUM_WORDS] = '{default: '0};

    // input stage
    logic                 nce_q = 1'b1;     // idle until the first edge
    logic                 nwe_q;
    logic [ADDR_BITS-1:0] addr_q;
    logic [WORD_SIZE-1:0] wdata_q;
    logic [MASK_BITS-1:0] wmask_q;

    always_ff @(posedge clk) begin
        nce_q   <= port.nce;
        nwe_q   <= port.nwe;
        addr_q  <= port.addr;
        wdata_q <= port.wdata;
        wmask_q <= port.wmask;
    end

    // access one edge after capture
    always_ff @(posedge clk) begin
        if (!nce_q) begin
            if (!nwe_q) begin
                // only the enabled bytes change
                for (int i = 0; i < MASK_BITS; i++) begin
                    if (wmask_q[i]) begin
                        array[addr_q][i*WRITE_SIZE +: WRITE_SIZE] <=
                            wdata_q[i*WRITE_SIZE +: WRITE_SIZE];
                    end
                end
            end else begin
                port.rdata <= array[addr_q];    // read port keeps last value
            end
        end
    end

endmodule

// ==== mem_req_sched.sv ====
`include "mem_sub_cfg.svh"

module mem_req_sched import mem_sub_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // requests from the requester
    input  logic      req_valid,
    input  logic      req_write,
    input  mem_addr_t req_addr,
    input  mem_data_t req_wdata,
    input  mem_mask_t req_wmask,
    input  mem_tag_t  req_tag,
    output logic      req_credit,

    // read responses
    output logic      resp_valid,
    output mem_data_t resp_data,
    output mem_tag_t  resp_tag,
    input  logic      resp_credit,

    mem_port_if.ctrl  mem
);

    localparam int DEPTH     = `REQ_CREDITS;
    localparam int PTR_BITS  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS  = $clog2(DEPTH + 1);
    localparam int RESP_BITS = $clog2(`RESP_CREDITS + 1);

    // request fifo
    mem_req_t            fifo_mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] fifo_cnt;
    logic                fifo_empty;
    mem_req_t            incoming;
    mem_req_t            head;

    // issue control
    logic                push;
    logic                pop;
    logic                issue_rd;
    logic                issue_wr;
    logic [RESP_BITS-1:0] resp_cnt;    // free response slots

    // read return tracking
    logic [1:0]          rd_vld_q;
    mem_tag_t            rd_tag_q [2];

    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign incoming = '{
        write: req_write,
        addr:  req_addr,
        data:  req_wdata,
        mask:  req_wmask,
        tag:   req_tag
    };

    // requester only sends while holding a credit, so the fifo never overflows
    assign push       = req_valid;
    assign fifo_empty = (fifo_cnt == '0);
    assign head       = fifo_mem[rd_ptr];

    // a read at the head waits for a response slot and blocks everything behind it
    assign issue_wr = !fifo_empty && head.write;
    assign issue_rd = !fifo_empty && !head.write && (resp_cnt != '0);
    assign pop      = issue_wr || issue_rd;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= incoming;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    // head goes straight to the memory input registers
    assign mem.nce   = !pop;
    assign mem.nwe   = !issue_wr;
    assign mem.addr  = head.addr;
    assign mem.wdata = head.data;
    assign mem.wmask = head.mask;

    // credit bookkeeping
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_cnt   <= RESP_BITS'(`RESP_CREDITS);
            req_credit <= 1'b0;
        end else begin
            req_credit <= pop;      // one pulse per request leaving the fifo
            case ({issue_rd, resp_credit})
                2'b10:   resp_cnt <= resp_cnt - 1'b1;
                2'b01:   resp_cnt <= resp_cnt + 1'b1;
                default: resp_cnt <= resp_cnt;
            endcase
        end
    end

    // stage 0 lines up with the memory capture, stage 1 with rdata
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_vld_q   <= '0;
            resp_valid <= 1'b0;
        end else begin
            rd_vld_q   <= {rd_vld_q[0], issue_rd};
            resp_valid <= rd_vld_q[1];
        end
    end

    always_ff @(posedge clk) begin
        rd_tag_q[0] <= head.tag;
        rd_tag_q[1] <= rd_tag_q[0];
        resp_tag    <= rd_tag_q[1];
        resp_data   <= mem.rdata;   // sampled before a following read replaces it
    end

endmodule

// ==== mem_sub_top.sv ====
`include "mem_sub_cfg.svh"

module mem_sub_top import mem_sub_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  logic      req_valid,
    input  logic      req_write,
    input  mem_addr_t req_addr,
    input  mem_data_t req_wdata,
    input  mem_mask_t req_wmask,
    input  mem_tag_t  req_tag,
    output logic      req_credit,

    output logic      resp_valid,
    output mem_data_t resp_data,
    output mem_tag_t  resp_tag,
    input  logic      resp_credit
);

    mem_port_if mem_if ();

    mem_req_sched sched0 (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wmask   (req_wmask),
        .req_tag     (req_tag),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_tag    (resp_tag),
        .resp_credit (resp_credit),
        .mem         (mem_if.ctrl)
    );

    // behavioral single port array
    mem_rtl_1rw #(
        .WORD_SIZE  (`MEM_WORD_BITS),
        .NUM_WORDS  (`MEM_WORDS),
        .WRITE_SIZE (`MEM_WRITE_BITS)
    ) mem0 (
        .clk  (clk),
        .port (mem_if.ram)
    );

endmodule

// ==== mem_sub_props.sv ====
`include "mem_sub_cfg.svh"

module mem_sub_props #(
    parameter int RESP_BITS = $clog2(`RESP_CREDITS + 1)
) (
    input logic                 clk,
    input logic                 reset,
    input logic                 resp_valid,
    input logic                 req_credit,
    input logic [RESP_BITS-1:0] resp_cnt,
    input logic                 nce
);

    // registered outputs are cleared by the first reset edge
    quiet_in_reset: assert property (
        @(posedge clk) reset |=> (!resp_valid && !req_credit)
    ) else $error("response or request credit active during reset");

    resp_cnt_bound: assert property (
        @(posedge clk) disable iff (reset) resp_cnt <= `RESP_CREDITS
    ) else $error("response credit count above its limit");

    // fifo is empty right after reset, so no access may start
    nce_idle_after_reset: assert property (
        @(posedge clk) reset |=> nce
    ) else $error("memory enabled in the cycle after reset");

endmodule

bind mem_req_sched mem_sub_props props0 (
    .clk        (clk),
    .reset      (reset),
    .resp_valid (resp_valid),
    .req_credit (req_credit),
    .resp_cnt   (resp_cnt),
    .nce        (mem.nce)
);

// ==== mem_sub_tb.sv ====
`include "mem_sub_cfg.svh"

module mem_sub_tb import mem_sub_pkg::*; ();

    localparam int N_ENTRIES = 39;
    localparam int WAIT_MAX  = 200;

    typedef struct {
        mem_req_t req;
        bit       hold;     // withhold response credits while these run
    } stim_t;

    logic      clk;
    logic      reset;
    logic      req_valid;
    logic      req_write;
    mem_addr_t req_addr;
    mem_data_t req_wdata;
    mem_mask_t req_wmask;
    mem_tag_t  req_tag;
    logic      req_credit;
    logic      resp_valid;
    mem_data_t resp_data;
    mem_tag_t  resp_tag;
    logic      resp_credit;

    stim_t     stim_tab [N_ENTRIES];
    int        n_built;
    mem_data_t ref_mem [`MEM_WORDS];
    mem_req_t  exp_q [$];      // expected reads, in issue order
    integer    seed;
    int        sent;
    int        pulses;         // req_credit pulses seen
    int        owed;           // responses consumed, credit not yet returned
    bit        holding;

    mem_sub_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wmask   (req_wmask),
        .req_tag     (req_tag),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_tag    (resp_tag),
        .resp_credit (resp_credit)
    );

    always #5 clk = ~clk;

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("FAIL at time %0t: %s, got %h expected %h", $time, what, got, expected);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_error(input string msg);
        $display("at time %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped on error");
    endtask

    task automatic add_entry(input bit write, input mem_addr_t addr, input mem_data_t data,
                             input mem_mask_t mask, input bit hold);
        stim_tab[n_built].req.write = write;
        stim_tab[n_built].req.addr  = addr;
        stim_tab[n_built].req.data  = data;
        stim_tab[n_built].req.mask  = mask;
        stim_tab[n_built].req.tag   = mem_tag_t'(n_built);
        stim_tab[n_built].hold      = hold;
        n_built++;
    endtask

    task automatic build_table();
        mem_addr_t a;
        n_built = 0;
        // full mask write then read back, plus an untouched word
        add_entry(1, 7'd5, 64'h0123_4567_89ab_cdef, 8'hff, 0);
        add_entry(0, 7'd5, '0, '0, 0);
        add_entry(0, 7'd100, '0, '0, 0);
        for (int i = 0; i < 8; i++) begin
            a = mem_addr_t'(16 + ($random(seed) & 32'h7));
            add_entry(1, a, {$random(seed), $random(seed)}, mem_mask_t'($random(seed)), 0);
        end
        for (int i = 0; i < 8; i++) begin
            add_entry(0, mem_addr_t'(16 + i), '0, '0, 0);
        end
        // write and read the same word back to back
        for (int k = 0; k < 2; k++) begin
            for (int j = 0; j < 2; j++) begin
                add_entry(1, mem_addr_t'(40 + k), {$random(seed), $random(seed)},
                          mem_mask_t'($random(seed)), 0);
                add_entry(0, mem_addr_t'(40 + k), '0, '0, 0);
            end
        end
        for (int i = 0; i < 8; i++) begin
            add_entry(0, mem_addr_t'(16 + i), '0, '0, 1);
        end
        add_entry(1, 7'd5, 64'hffff_ffff_ffff_ffff, 8'h0f, 0);
        add_entry(0, 7'd5, '0, '0, 0);
        add_entry(0, 7'd100, '0, '0, 0);
        add_entry(0, 7'd16, '0, '0, 0);
    endtask

    // masked write into the reference array
    task automatic model_write(input mem_req_t r);
        for (int b = 0; b < `MEM_WORD_BITS / `MEM_WRITE_BITS; b++) begin
            if (r.mask[b]) begin
                ref_mem[r.addr][b*8 +: 8] = r.data[b*8 +: 8];
            end
        end
    endtask

    task automatic send_req(input int i);
        int       waited;
        mem_req_t r;
        mem_req_t e;
        waited = 0;
        while (sent - pulses >= `REQ_CREDITS) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_MAX) begin
                report_error("no request credit came back in time");
            end
        end
        r = stim_tab[i].req;
        req_valid = 1'b1;
        req_write = r.write;
        req_addr  = r.addr;
        req_wdata = r.data;
        req_wmask = r.mask;
        req_tag   = r.tag;
        sent++;
        if (r.write) begin
            model_write(r);
        end else begin
            e = r;
            e.data = ref_mem[r.addr];
            exp_q.push_back(e);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // wait until every read has answered and every credit is back
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || owed != 0 || pulses != sent || resp_credit) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_MAX) begin
                report_error("outstanding requests did not finish in time");
            end
        end
    endtask

    // requester side of the response credits
    always begin
        @(posedge clk);
        #1;
        if (!reset && !holding && owed > 0) begin
            resp_credit = 1'b1;
            owed--;
        end else begin
            resp_credit = 1'b0;
        end
    end

    // outputs sampled mid cycle
    always @(negedge clk) begin
        mem_req_t e;
        if (!reset && resp_valid) begin
            if (exp_q.size() == 0) begin
                report_error("response arrived with no read outstanding");
            end
            e = exp_q.pop_front();
            check_value(resp_tag, e.tag, "response tag");
            check_value(resp_data, e.data, "response data");
            owed++;
            if (owed > `RESP_CREDITS) begin
                report_error("more responses than response credits");
            end
        end
        if (!reset && req_credit) begin
            pulses++;
            if (pulses > sent) begin
                report_error("request credit returned without a request");
            end
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_wmask   = '0;
        req_tag     = '0;
        resp_credit = 1'b0;
        seed        = 73872;
        sent        = 0;
        pulses      = 0;
        owed        = 0;
        holding     = 1'b0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        build_table();

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < N_ENTRIES; i++) begin
            if (stim_tab[i].hold && !holding) begin
                drain();
                holding = 1'b1;
            end
            send_req(i);
            if (holding && (i == N_ENTRIES - 1 || !stim_tab[i + 1].hold)) begin
                // observation window with no credits returned
                for (int c = 0; c < 20; c++) begin
                    @(posedge clk);
                    #1;
                end
                check_value(owed, `RESP_CREDITS, "responses while credits withheld");
                check_value(exp_q.size(), 4, "reads still waiting");
                check_value(sent - pulses, `REQ_CREDITS, "request credits held back");
                holding = 1'b0;
            end
        end
        drain();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== mem_sub_top.f ====
+incdir+.
mem_sub_pkg.sv
mem_port_if.sv
mem_rtl_1rw.sv
mem_req_sched.sv
mem_sub_top.sv
mem_sub_props.sv
mem_sub_tb.sv
